// File: bench/rx8b9b_tb.sv
// --------------------
// Testbench for rx8b9b_top. Lines are modelled at 4x oversampling, idle high.
// Expected words come from a scoreboard queue per lane.
// --------------------
`timescale 1ns/1ps
`include "rx8b9b_config.svh"

module rx8b9b_tb;

	logic                      clk = 1'b0;
	logic                      async_reset;
	logic                      enable;
	logic [`RX_LANES-1:0][3:0] samples; // Bit 0 earliest
	rx8b9b_pkg::rx_word_t      word_out;
	logic                      word_valid;

	bit                     line_q [`RX_LANES][$]; // Samples still to be driven, per lane
	rx8b9b_pkg::lane_word_t exp_q  [`RX_LANES][$]; // Words in send order, per lane
	int seed;
	int errors        = 0;
	int words_checked = 0;
	int total_samples = 0; // Everything queued so far, sizes the watchdog
	int cycle_cnt     = 0;
	int quiet_cnt     = 0; // Cycles since reset release, saturating

	rx8b9b_top DUT (
		.clk         (clk),
		.async_reset (async_reset),
		.enable      (enable),
		.samples     (samples),
		.word_out    (word_out),
		.word_valid  (word_valid)
	);

	always #4 clk = ~clk; // 8 ns period

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (async_reset)
			quiet_cnt <= 0;
		else if (quiet_cnt < 64)
			quiet_cnt <= quiet_cnt + 1;
	end

	// Nothing may leave the merger during reset or the hold after it
	a_quiet_after_reset: assert property (
		@(posedge clk) (async_reset || quiet_cnt < `RX_RESET_HOLD) |=> !word_valid
	) else begin
		errors++;
		$display("word_valid went high during reset or the reset hold");
	end

	a_lane_tag: assert property (
		@(posedge clk) disable iff (async_reset) word_valid |-> int'(word_out.lane) < `RX_LANES
	) else begin
		errors++;
		$display("** Error: word_out.lane expected below %h got %h", `RX_LANES, word_out.lane);
	end

	function automatic int random_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// True while any line still has samples or any word is outstanding
	function automatic bit traffic_pending();
		bit busy;
		busy = 1'b0;
		for (int l = 0; l < `RX_LANES; l++) begin
			if (line_q[l].size() != 0 || exp_q[l].size() != 0)
				busy = 1'b1;
		end
		return busy;
	endfunction

	task automatic push_level(input int lane, input bit level, input int count);
		for (int i = 0; i < count; i++)
			line_q[lane].push_back(level);
		total_samples += count;
	endtask

	// One frame on one lane, start bit begins at sample index offset of a nibble
	task automatic queue_frame(input int lane, input int offset, input int n_words,
			input logic [31:0] bytes, input bit record);
		rx8b9b_pkg::lane_word_t exp_word;
		push_level(lane, 1'b1, 4 + offset); // Full idle nibble, then the phase
		push_level(lane, 1'b0, 4);          // Start bit
		for (int w = 0; w < n_words; w++) begin
			for (int b = 0; b < 8; b++)
				push_level(lane, bytes[8*w + b], 4); // LSB first
			push_level(lane, w == n_words - 1, 4);   // Flag, 1 ends the frame
			exp_word.last = (w == n_words - 1);
			exp_word.data = bytes[8*w +: 8];
			if (record)
				exp_q[lane].push_back(exp_word);
		end
		push_level(lane, 1'b1, 8); // Gap so the lane is idle before the next start
		while (line_q[lane].size() % 4 != 0)
			push_level(lane, 1'b1, 1);
	endtask

	task automatic check_output();
		rx8b9b_pkg::lane_word_t exp_word;
		int                     lane;
		bit                     have_exp;
		if (!async_reset && word_valid) begin
			lane     = int'(word_out.lane);
			have_exp = 1'b0;
			if (lane < `RX_LANES)
				have_exp = exp_q[lane].size() != 0;
			assert (have_exp) else begin
				errors++;
				$display("A word came out of lane %0d while none was outstanding there", lane);
			end
			if (have_exp) begin
				exp_word = exp_q[lane].pop_front();
				words_checked++;
				assert (word_out.word == exp_word) else begin
					errors++;
					$display("** Error: word_out.word lane %0d expected %h got %h",
						lane, exp_word, word_out.word);
				end
			end
		end
	endtask

	// Outputs are checked and the next nibbles driven on the falling edge
	task automatic step();
		logic [`RX_LANES-1:0][3:0] nib;
		@(negedge clk);
		check_output();
		for (int l = 0; l < `RX_LANES; l++) begin
			for (int s = 0; s < 4; s++) begin
				if (line_q[l].size() != 0)
					nib[l][s] = line_q[l].pop_front();
				else
					nib[l][s] = 1'b1; // Idle line
			end
		end
		samples = nib;
	endtask

	task automatic drain();
		while (traffic_pending())
			step();
		repeat (12) step(); // Room for a stray word to show up
	endtask

	// Four reset cycles, an all ones frame puts only its start bit into the hold
	task automatic apply_reset();
		async_reset = 1'b1;
		repeat (3) step();
		for (int l = 0; l < `RX_LANES; l++)
			queue_frame(l, random_below(4), 1, 32'hffff_ffff, 1'b0);
		step();
		async_reset = 1'b0;
	endtask

	initial begin : stimulus
		seed        = 18983;
		async_reset = 1'b1;
		enable      = 1'b1;
		samples     = '1;
		apply_reset();
		drain();

		// Single words, every lane at every offset, offset 3 wraps the sample point
		for (int off = 0; off < 4; off++) begin
			for (int l = 0; l < `RX_LANES; l++)
				queue_frame(l, (off + l) % 4, 1, $random(seed), 1'b1);
			drain();
		end

		// Frames of 1 to 4 words, two per lane back to back, all lanes at once
		for (int r = 0; r < 4; r++) begin
			for (int l = 0; l < `RX_LANES; l++) begin
				repeat (2)
					queue_frame(l, random_below(4), 1 + random_below(4), $random(seed), 1'b1);
			end
			drain();
		end

		// Disabled lanes must ignore whole frames
		enable = 1'b0;
		for (int l = 0; l < `RX_LANES; l++)
			queue_frame(l, random_below(4), 1 + random_below(4), $random(seed), 1'b0);
		drain();
		enable = 1'b1;
		for (int l = 0; l < `RX_LANES; l++)
			queue_frame(l, random_below(4), 1 + random_below(4), $random(seed), 1'b1);
		drain();

		// Reset in the middle of the run, then normal traffic again
		apply_reset();
		for (int l = 0; l < `RX_LANES; l++)
			queue_frame(l, random_below(4), 1 + random_below(4), $random(seed), 1'b1);
		drain();

		for (int l = 0; l < `RX_LANES; l++) begin
			assert (exp_q[l].size() == 0) else begin
				errors++;
				$display("Lane %0d still has %0d words that never came out", l, exp_q[l].size());
			end
		end
		$display("Errors: %0d, words checked: %0d", errors, words_checked);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Budget is one cycle per queued bit plus 200 cycles
	initial begin : watchdog
		@(posedge clk);
		while (cycle_cnt <= total_samples / 4 + 200)
			@(posedge clk);
		$display("Timeout after %0d cycles, expected words never arrived", cycle_cnt);
		$display("Errors: %0d, words checked: %0d", errors, words_checked);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: common/rx8b9b_config.svh
// --------------------
// Build-time sizes of the receiver. RX_LANES must stay within 1..8
// (3-bit lane tag), RX_RESET_HOLD must be at least 1
// --------------------
`ifndef RX8B9B_CONFIG_SVH
`define RX8B9B_CONFIG_SVH

// Number of serial lanes, each delivering one 4-sample nibble per clk
`define RX_LANES 4

// Data bits per word, sent LSB first after the start bit
`define RX_WORD_WIDTH 8

// Cycles the lane receivers stay idle once reset is released
`define RX_RESET_HOLD 4

`endif

// File: common/rx8b9b_pkg.sv
// --------------------
// Shared types of the 8b9b receiver. Sizes come from rx8b9b_config.svh
// --------------------
`include "rx8b9b_config.svh"

package rx8b9b_pkg;

	// Lane number, 3 bits so at most 8 lanes
	typedef logic [2:0] lane_idx_t;

	// Registered samples of one lane, bit 0 is the earliest sample
	typedef struct packed {
		logic [3:0] prev; // Nibble from the cycle before, for late sample points
		logic [3:0] cur;  // Newest nibble
	} sample_pair_t;

	// One decoded word as it leaves a lane receiver
	typedef struct packed {
		logic                      last; // Flag bit was 1, frame ends here
		logic [`RX_WORD_WIDTH-1:0] data; // First received bit sits at bit 0
	} lane_word_t;

	// Merged output word, tagged with its source lane
	typedef struct packed {
		lane_idx_t  lane;
		lane_word_t word;
	} rx_word_t;

endpackage

// File: lane_rx/lane_rx_8b9b.sv
// --------------------
// Single lane 8b9b receiver working on 4x oversampled nibbles.
// No bit slip and no framing checks, a missing start bit goes unnoticed
// --------------------
`timescale 1ns/1ps
`include "rx8b9b_config.svh"

module lane_rx_8b9b (
	input  logic                     clk,
	input  logic                     async_reset, // Sync, active high
	input  logic                     run,         // Low holds the lane idle
	input  logic                     enable,      // Gates new frames only
	input  rx8b9b_pkg::sample_pair_t pair,
	output rx8b9b_pkg::lane_word_t   word,
	output logic                     word_strobe  // One cycle per word
);

	localparam int CNT_W = $clog2(`RX_WORD_WIDTH);

	typedef enum logic [1:0] {
		ST_IDLE,    // Wait for the line to go low
		ST_SKIP,    // Picked bit is the start bit
		ST_RECEIVE, // Shift in data bits
		ST_COMMIT   // Picked bit is the flag
	} state_t;

	state_t                    state;
	logic [1:0]                latch_pt;   // 0 means index 0 of the next nibble
	logic [1:0]                start_pt;   // Point derived from the current nibble
	logic [CNT_W-1:0]          bit_cnt;    // Data bits still to come, minus one
	logic [`RX_WORD_WIDTH-1:0] shreg;
	logic                      picked_bit;
	logic                      start_seen;

	// Sample point is one sample after the first low sample
	always_comb begin
		if (!pair.cur[0])
			start_pt = 2'd1;
		else if (!pair.cur[1])
			start_pt = 2'd2;
		else if (!pair.cur[2])
			start_pt = 2'd3;
		else
			start_pt = 2'd0; // Edge at index 3, point wraps into the next nibble
	end

	assign start_seen = (pair.cur != 4'hf) && run && enable;

	// Points 1..3 lie in the older nibble, point 0 in the newer one
	// so every picked bit belongs to the same bit period
	always_comb begin
		if (latch_pt == 2'd0)
			picked_bit = pair.cur[0];
		else
			picked_bit = pair.prev[latch_pt];
	end

	// Frame FSM
	always_ff @(posedge clk) begin
		if (async_reset || !run) begin
			state       <= ST_IDLE;
			latch_pt    <= 2'd0;
			bit_cnt     <= '0;
			word_strobe <= 1'b0;
		end else begin
			word_strobe <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start_seen) begin
						latch_pt <= start_pt;
						state    <= ST_SKIP;
					end
				end
				ST_SKIP: begin // Start bit is dropped here
					bit_cnt <= CNT_W'(`RX_WORD_WIDTH - 1);
					state   <= ST_RECEIVE;
				end
				ST_RECEIVE: begin
					bit_cnt <= bit_cnt - 1'b1;
					if (bit_cnt == '0)
						state <= ST_COMMIT;
				end
				ST_COMMIT: begin
					word_strobe <= 1'b1;
					bit_cnt     <= CNT_W'(`RX_WORD_WIDTH - 1);
					// Flag 0 means the next data bit follows right away
					state       <= picked_bit ? ST_IDLE : ST_RECEIVE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Data path, LSB arrives first so shift in from the top
	always_ff @(posedge clk) begin
		if (state == ST_RECEIVE)
			shreg <= {picked_bit, shreg[`RX_WORD_WIDTH-1:1]};
		if (state == ST_COMMIT) begin
			word.data <= shreg;
			word.last <= picked_bit; // Flag 1 closes the frame
		end
	end

	// Commit is always followed by at least eight receive cycles
	a_strobe_gap: assert property (
		@(posedge clk) disable iff (async_reset) word_strobe |=> !word_strobe
	) else $error("word_strobe high on back to back cycles");

endmodule

// File: list.f
+incdir+common
common/rx8b9b_pkg.sv
verilog/sample_retimer.sv
lane_rx/lane_rx_8b9b.sv
verilog/word_merger.sv
verilog/rx8b9b_top.sv
bench/rx8b9b_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the receiver testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module rx8b9b_tb -o rx8b9b_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/rx8b9b_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
echo "Simulation reported failure"
exit 1

// File: verilog/rx8b9b_top.sv
// --------------------
// Multi-lane 8b9b receiver top. Inputs are already 1:4 deserialized,
// no back-pressure on the output stream
// --------------------
`timescale 1ns/1ps
`include "rx8b9b_config.svh"

module rx8b9b_top (
	input  logic                      clk,
	input  logic                      async_reset, // Sync, active high
	input  logic                      enable,
	input  logic [`RX_LANES-1:0][3:0] samples,     // Bit 0 earliest
	output rx8b9b_pkg::rx_word_t      word_out,
	output logic                      word_valid
);

	rx8b9b_pkg::sample_pair_t [`RX_LANES-1:0] pairs;
	rx8b9b_pkg::lane_word_t   [`RX_LANES-1:0] lane_words;
	logic [`RX_LANES-1:0]                     lane_strobes;
	logic                                     run;
	logic                                     enable_r;

	sample_retimer u_retimer (
		.clk         (clk),
		.async_reset (async_reset),
		.enable      (enable),
		.samples     (samples),
		.pairs       (pairs),
		.run         (run),
		.enable_r    (enable_r)
	);

	// One receiver per lane
	for (genvar l = 0; l < `RX_LANES; l++) begin : g_lane
		lane_rx_8b9b u_lane (
			.clk         (clk),
			.async_reset (async_reset),
			.run         (run),
			.enable      (enable_r),
			.pair        (pairs[l]),
			.word        (lane_words[l]),
			.word_strobe (lane_strobes[l])
		);
	end

	word_merger u_merger (
		.clk          (clk),
		.async_reset  (async_reset),
		.lane_words   (lane_words),
		.lane_strobes (lane_strobes),
		.word_out     (word_out),
		.word_valid   (word_valid)
	);

endmodule

// File: verilog/sample_retimer.sv
// --------------------
// Retimes all lane nibbles and generates the run level.
// run rises RX_RESET_HOLD cycles after async_reset drops
// --------------------
`timescale 1ns/1ps
`include "rx8b9b_config.svh"

module sample_retimer (
	input  logic                                     clk,
	input  logic                                     async_reset, // Sync, active high
	input  logic                                     enable,
	input  logic [`RX_LANES-1:0][3:0]                samples,     // Bit 0 earliest
	output rx8b9b_pkg::sample_pair_t [`RX_LANES-1:0] pairs,
	output logic                                     run,
	output logic                                     enable_r
);

	localparam int HOLD_W = $clog2(`RX_RESET_HOLD + 1);

	logic [HOLD_W-1:0] hold_cnt; // Counts cycles since reset release

	// Two sample stages per lane
	// cur follows the pins by one cycle, prev trails cur by one more
	always_ff @(posedge clk) begin
		for (int l = 0; l < `RX_LANES; l++) begin
			pairs[l].cur  <= samples[l];
			pairs[l].prev <= pairs[l].cur;
		end
	end

	// Reset hold, lanes only start once the sample pipe has settled
	always_ff @(posedge clk) begin
		if (async_reset) begin
			hold_cnt <= '0;
			run      <= 1'b0;
			enable_r <= 1'b0;
		end else begin
			enable_r <= enable;
			if (!run) begin
				hold_cnt <= hold_cnt + 1'b1;
				if (hold_cnt == HOLD_W'(`RX_RESET_HOLD - 1))
					run <= 1'b1; // Stays high until the next reset
			end
		end
	end

	// run may only drop as a result of reset
	a_run_no_fall: assert property (
		@(posedge clk) $fell(run) |-> $past(async_reset)
	) else $error("run fell without a reset");

endmodule

// File: verilog/word_merger.sv
// --------------------
// Round-robin merge of all lane words into one tagged stream.
// One slot per lane, relies on strobes being at least 9 cycles apart
// --------------------
`timescale 1ns/1ps
`include "rx8b9b_config.svh"

module word_merger (
	input  logic                                   clk,
	input  logic                                   async_reset, // Sync, active high
	input  rx8b9b_pkg::lane_word_t [`RX_LANES-1:0] lane_words,
	input  logic [`RX_LANES-1:0]                   lane_strobes,
	output rx8b9b_pkg::rx_word_t                   word_out,
	output logic                                   word_valid   // One cycle per word
);

	localparam int L = `RX_LANES;

	rx8b9b_pkg::lane_word_t slot_word [L]; // Held word per lane
	logic [L-1:0]           slot_full;
	logic [L-1:0]           pending;       // Held or arriving this cycle
	logic [L-1:0]           clear_mask;
	rx8b9b_pkg::lane_idx_t  last;          // Lane served most recently
	rx8b9b_pkg::lane_word_t pick_word;
	logic                   pick_valid;
	int                     pick_i;

	// Search starts one past the last served lane
	always_comb begin
		int idx;
		pending    = slot_full | lane_strobes;
		pick_valid = 1'b0;
		pick_i     = 0;
		for (int k = 1; k <= L; k++) begin
			idx = (int'(last) + k) % L;
			if (!pick_valid && pending[idx]) begin
				pick_valid = 1'b1;
				pick_i     = idx;
			end
		end
		clear_mask = '0;
		if (pick_valid)
			clear_mask[pick_i] = 1'b1;
		// A word strobed this cycle bypasses its slot
		pick_word = slot_full[pick_i] ? slot_word[pick_i] : lane_words[pick_i];
	end

	always_ff @(posedge clk) begin
		if (async_reset) begin
			slot_full  <= '0;
			word_valid <= 1'b0;
			last       <= rx8b9b_pkg::lane_idx_t'(L - 1); // Lane 0 goes first
		end else begin
			slot_full  <= pending & ~clear_mask;
			word_valid <= pick_valid;
			if (pick_valid)
				last <= rx8b9b_pkg::lane_idx_t'(pick_i);
		end
	end

	// Payload
	always_ff @(posedge clk) begin
		for (int l = 0; l < L; l++) begin
			if (lane_strobes[l])
				slot_word[l] <= lane_words[l];
		end
		if (pick_valid)
			word_out <= {rx8b9b_pkg::lane_idx_t'(pick_i), pick_word};
	end

	// A lane strobes at most every 9 cycles, all lanes drain within 8
	a_no_overflow: assert property (
		@(posedge clk) disable iff (async_reset) (lane_strobes & slot_full) == '0
	) else $error("lane word arrived into a full slot");

	a_served_full: assert property (
		@(posedge clk) disable iff (async_reset)
		word_valid |-> ((($past(pending) >> word_out.lane) & 1'b1) != '0)
	) else $error("word_valid from an empty slot");

endmodule
